// ==== design/rst_seq_defs.svh ====
// Build-time sizes for the staged reset sequencer
// Included by the packages and by any module that sizes logic from these values

`ifndef RST_SEQ_DEFS_SVH
`define RST_SEQ_DEFS_SVH

// Pipeline shape
`define RST_N_STAGES 3        // Stages released in order 0 -> 2
`define RST_IP_NUM 4          // IP resets formed per stage
`define RST_SRC_NUM 2         // Maskable hardware reset sources per stage

// Release timing
`define RST_SYNC_DEPTH 3      // Flops in each release synchronizer
`define RST_STRETCH_W 12      // Up to 4095 extra cycles of stretch

// Bit k set builds a synchronizer and stretcher in stage k
// Stage 0 follows the top reset combinationally
`define RST_STRETCH_MASK 3'b110

`endif

// ==== design/rst_cfg_pkg.sv ====
// Configuration types of the reset sequencer
// Stretch counts and hardware source vectors, single stage and per-stage arrays

`include "rst_seq_defs.svh"

package rst_cfg_pkg;

  // Release stretch in i_clk cycles, zero bypasses the stretcher
  typedef logic [`RST_STRETCH_W-1:0] stretch_t;

  // One bit per hardware source
  // Same shape for the active-low source resets and their masks
  typedef logic [`RST_SRC_NUM-1:0] src_vec_t;

  // Per-stage arrays as seen at the top, index = stage number
  typedef stretch_t [`RST_N_STAGES-1:0] stretch_arr_t;
  typedef src_vec_t [`RST_N_STAGES-1:0] src_arr_t;

endpackage

// ==== design/rst_ip_pkg.sv ====
// Per-IP types of the reset sequencer
// Used for IP resets, software resets, force bits and acknowledges

`include "rst_seq_defs.svh"

package rst_ip_pkg;

  // One bit per IP in a stage
  typedef logic [`RST_IP_NUM-1:0] ip_vec_t;

  // IP vectors of all stages, index = stage number
  typedef ip_vec_t [`RST_N_STAGES-1:0] ip_arr_t;

endpackage

// ==== design/rst_n_sync.sv ====
// Reset synchronizer, asserts asynchronously and releases after DEPTH edges of i_clk
// In test mode the output is taken straight from i_test_rst_n

module rst_n_sync #(
  parameter int unsigned DEPTH = 2  // Number of flops in the chain
) (
  input  logic i_clk,
  input  logic i_rst_n,       // Async assert, sync release
  input  logic i_test_mode,
  input  logic i_test_rst_n,  // Replaces the synced reset in test mode
  output logic o_rst_n
);

  logic [DEPTH-1:0] sync_q;  // Bit 0 samples first

  if (DEPTH < 2) begin : g_depth_check
    $error("rst_n_sync needs at least two flops");
  end

  // Chain clears on assert, fills with ones after release
  always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) begin
      sync_q <= '0;
    end else begin
      sync_q <= {sync_q[DEPTH-2:0], 1'b1};
    end
  end

  assign o_rst_n = i_test_mode ? i_test_rst_n : sync_q[DEPTH-1];  // DFT bypass

  // Functional release needs the input high now and DEPTH-1 edges back
  a_release_after_depth: assert property (@(posedge i_clk)
    (o_rst_n && !i_test_mode) |-> (i_rst_n && $past(i_rst_n, DEPTH-1)));

endmodule

// ==== design/rst_stage_block.sv ====
// One stage of the reset sequencer
// Merges reset inputs, optionally syncs and stretches release, forms IP resets and ack
// Chain o_rst_n into the next stage's i_rst_n to order the release

`include "rst_seq_defs.svh"

module rst_stage_block #(
  parameter bit USE_STRETCH = 1'b0  // Build synchronizer and stretch counter
) (
  input  logic                  i_clk,
  input  logic                  i_test_mode,
  input  logic                  i_test_rst_n,
  input  rst_cfg_pkg::stretch_t i_stretch_cycles,  // Extra release delay
  input  logic                  i_rst_n,           // Broadcast or upstream stage reset
  input  logic                  i_rst_req_n,       // Software request for the whole stage
  input  rst_cfg_pkg::src_vec_t i_rst_src_n,       // Hardware sources, active low
  input  rst_cfg_pkg::src_vec_t i_mask_rst_src,    // Set to ignore a source
  input  rst_ip_pkg::ip_vec_t   i_rst_ip_force,    // Hold one IP in reset
  input  rst_ip_pkg::ip_vec_t   i_rst_ip_sw_n,     // Per-IP software reset
  input  rst_ip_pkg::ip_vec_t   i_ack_ip,          // High while the IP reports reset
  output logic                  o_rst_n,           // Next stage reset
  output logic                  o_rst_ack_n,       // Low when every IP acknowledges
  output rst_ip_pkg::ip_vec_t   o_rst_ip_n
);

  import rst_cfg_pkg::*;

  logic rst_stage_in_n;  // Merged reset before sync and stretch
  logic rst_stage_n;     // Stage reset driving the IPs
  logic all_ack;

  // Any input low asserts the stage, a masked source is forced high
  assign rst_stage_in_n = i_rst_n & i_rst_req_n & (&(i_rst_src_n | i_mask_rst_src));

  if (USE_STRETCH) begin : g_stretch
    logic     rst_sync_n;      // Synced merged reset, or test reset
    logic     rst_bypass_n;    // Used when the stretch value is zero
    logic     stretch_cnt_en;  // High while the stretch is still running
    logic     stretch_done;
    stretch_t stretch_cnt;

    rst_n_sync #(
      .DEPTH        (`RST_SYNC_DEPTH)
    ) u_rst_n_sync (
      .i_clk        (i_clk),
      .i_rst_n      (rst_stage_in_n),
      .i_test_mode  (i_test_mode),
      .i_test_rst_n (i_test_rst_n),
      .o_rst_n      (rst_sync_n)
    );

    // >= so a stretch value lowered mid-count still terminates
    assign stretch_done = (stretch_cnt >= i_stretch_cycles);

    always_ff @(posedge i_clk, negedge rst_sync_n) begin
      if (!rst_sync_n) begin
        stretch_cnt_en <= 1'b1;  // Restart on every assertion
      end else if (stretch_done) begin
        stretch_cnt_en <= 1'b0;  // Releases the stage on the next cycle
      end
    end

    always_ff @(posedge i_clk, negedge rst_sync_n) begin
      if (!rst_sync_n) begin
        stretch_cnt <= '0;
      end else if (stretch_cnt_en && !stretch_done) begin
        stretch_cnt <= stretch_cnt + stretch_t'(1);  // Holds at the stretch value
      end
    end

    // Zero stretch skips the synchronizer except in test mode,
    // where the test reset keeps full control of the stage
    assign rst_bypass_n = i_test_mode ? rst_sync_n : rst_stage_in_n;
    assign rst_stage_n  = (i_stretch_cycles == '0) ? rst_bypass_n : ~stretch_cnt_en;

    // Count stays in range while it runs, a larger count would wrap and release late
    a_cnt_in_range: assert property (@(posedge i_clk) disable iff (!rst_sync_n)
      stretch_cnt_en |-> (stretch_cnt <= i_stretch_cycles));

  end else begin : g_no_stretch
    assign rst_stage_n = rst_stage_in_n;  // Release follows the merged input directly
  end

  // IP reset = stage reset AND sw reset AND NOT force
  assign o_rst_ip_n = {`RST_IP_NUM{rst_stage_n}} & i_rst_ip_sw_n & ~i_rst_ip_force;

  assign all_ack     = &i_ack_ip;
  assign o_rst_ack_n = ~all_ack;
  // Stage fully in reset holds every later stage in reset as well
  assign o_rst_n     = rst_stage_n & ~all_ack;

  // Merged input held low for a full cycle keeps the IPs and the next stage in reset
  a_held_while_merged_low: assert property (@(posedge i_clk)
    (!i_test_mode && !rst_stage_in_n && $past(!rst_stage_in_n))
    |-> (!o_rst_n && o_rst_ip_n == '0));

endmodule

// ==== design/rst_seq_top.sv ====
// Top of the staged reset sequencer
// Chains the stages so stage k releases only after stage k-1, done is the last stage

`include "rst_seq_defs.svh"

module rst_seq_top (
  input  logic                          i_clk,
  input  logic                          rst_sync_n,        // Power-on reset into stage 0
  input  logic                          i_test_mode,
  input  logic                          i_test_rst_n,
  input  rst_cfg_pkg::stretch_arr_t     i_stretch_cycles,
  input  logic [`RST_N_STAGES-1:0]      i_rst_req_n,       // One request per stage
  input  rst_cfg_pkg::src_arr_t         i_rst_src_n,
  input  rst_cfg_pkg::src_arr_t         i_mask_rst_src,
  input  rst_ip_pkg::ip_arr_t           i_rst_ip_force,
  input  rst_ip_pkg::ip_arr_t           i_rst_ip_sw_n,
  input  rst_ip_pkg::ip_arr_t           i_ack_ip,
  output rst_ip_pkg::ip_arr_t           o_rst_ip_n,
  output logic [`RST_N_STAGES-1:0]      o_rst_ack_n,       // One ack per stage
  output logic                          o_rst_done_n       // Last stage released
);

  localparam bit [`RST_N_STAGES-1:0] STRETCH_MASK = `RST_STRETCH_MASK;

  // Element k feeds stage k, element k+1 comes out of it
  logic [`RST_N_STAGES:0] stage_rst_n;

  assign stage_rst_n[0] = rst_sync_n;

  for (genvar k = 0; k < `RST_N_STAGES; k++) begin : g_stage
    rst_stage_block #(
      .USE_STRETCH      (STRETCH_MASK[k])
    ) u_stage (
      .i_clk            (i_clk),
      .i_test_mode      (i_test_mode),
      .i_test_rst_n     (i_test_rst_n),
      .i_stretch_cycles (i_stretch_cycles[k]),
      .i_rst_n          (stage_rst_n[k]),      // Upstream stage or top reset
      .i_rst_req_n      (i_rst_req_n[k]),
      .i_rst_src_n      (i_rst_src_n[k]),
      .i_mask_rst_src   (i_mask_rst_src[k]),
      .i_rst_ip_force   (i_rst_ip_force[k]),
      .i_rst_ip_sw_n    (i_rst_ip_sw_n[k]),
      .i_ack_ip         (i_ack_ip[k]),
      .o_rst_n          (stage_rst_n[k+1]),    // Into the next stage
      .o_rst_ack_n      (o_rst_ack_n[k]),
      .o_rst_ip_n       (o_rst_ip_n[k])
    );
  end

  assign o_rst_done_n = stage_rst_n[`RST_N_STAGES];  // Sum of all stage delays

endmodule

// ==== bench/tb_rst_seq.sv ====
// Directed testbench for the staged reset sequencer
// Covers release order and stretch bounds, IP reset forming, masks, ack back-pressure, test mode

`include "rst_seq_defs.svh"

module tb_rst_seq;

  timeunit 1ns;
  timeprecision 1ps;

  import rst_cfg_pkg::*;
  import rst_ip_pkg::*;

  localparam int N_STAGES        = `RST_N_STAGES;
  localparam int N_TESTS         = 6;
  localparam int WATCHDOG_CYCLES = N_TESTS * (N_STAGES * (`RST_SYNC_DEPTH + 21) + 50);
  localparam bit [`RST_N_STAGES-1:0] STRETCH_MASK = `RST_STRETCH_MASK;

  logic                   i_clk;
  logic                   rst_sync_n;
  logic                   i_test_mode;
  logic                   i_test_rst_n;
  stretch_arr_t           i_stretch_cycles;
  logic [N_STAGES-1:0]    i_rst_req_n;
  src_arr_t               i_rst_src_n;
  src_arr_t               i_mask_rst_src;
  ip_arr_t                i_rst_ip_force;
  ip_arr_t                i_rst_ip_sw_n;
  ip_arr_t                i_ack_ip;
  ip_arr_t                o_rst_ip_n;
  logic [N_STAGES-1:0]    o_rst_ack_n;
  logic                   o_rst_done_n;

  stretch_arr_t stretch_rand;    // Drawn once, restored after the zero-stretch tests
  integer       seed;
  int           cyc = 0;         // Rising edges seen so far
  int           mismatch_cnt = 0;
  int           timing_cnt = 0;  // Missing or out-of-bound releases
  int           rel_cyc [N_STAGES];
  int           start_cyc;       // First sampled cycle of a release measurement

  rst_seq_top u_dut (
    .i_clk            (i_clk),
    .rst_sync_n       (rst_sync_n),
    .i_test_mode      (i_test_mode),
    .i_test_rst_n     (i_test_rst_n),
    .i_stretch_cycles (i_stretch_cycles),
    .i_rst_req_n      (i_rst_req_n),
    .i_rst_src_n      (i_rst_src_n),
    .i_mask_rst_src   (i_mask_rst_src),
    .i_rst_ip_force   (i_rst_ip_force),
    .i_rst_ip_sw_n    (i_rst_ip_sw_n),
    .i_ack_ip         (i_ack_ip),
    .o_rst_ip_n       (o_rst_ip_n),
    .o_rst_ack_n      (o_rst_ack_n),
    .o_rst_done_n     (o_rst_done_n)
  );

  initial begin
    i_clk = 1'b0;
    forever #10 i_clk = ~i_clk;  // 20 ns period
  end

  always @(posedge i_clk) cyc <= cyc + 1;

  // Settled level of stage k's reset, from the merge rules and the chain
  function automatic logic stage_level(input int k);
    logic lvl;
    lvl = rst_sync_n;
    for (int j = 0; j <= k; j++) begin
      if (j > 0) lvl &= ~&i_ack_ip[j-1];  // Upstream fully acked holds this stage
      if (i_test_mode && STRETCH_MASK[j]) begin
        lvl = i_test_rst_n;               // Test reset takes over stretcher stages
      end else begin
        lvl &= i_rst_req_n[j] & (&(i_rst_src_n[j] | i_mask_rst_src[j]));
      end
    end
    return lvl;
  endfunction

  function automatic ip_vec_t expected_ip(input int k);
    return {`RST_IP_NUM{stage_level(k)}} & i_rst_ip_sw_n[k] & ~i_rst_ip_force[k];
  endfunction

  // Exact release delay of stage k behind its input
  function automatic int min_delay(input int k);
    if (STRETCH_MASK[k] && i_stretch_cycles[k] != '0) begin
      return `RST_SYNC_DEPTH + int'(i_stretch_cycles[k]) + 1;
    end
    return 0;
  endfunction

  function automatic int max_delay(input int k);
    return STRETCH_MASK[k] ? `RST_SYNC_DEPTH + int'(i_stretch_cycles[k]) + 1 : 0;
  endfunction

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("mismatch at %0t: %s expected %b actual %b", $time, name, exp, act);
      mismatch_cnt++;
    end
  endtask

  task automatic check_ip_rst(input string name, input ip_vec_t exp, input ip_vec_t act);
    if (act !== exp) begin
      $display("mismatch at %0t: %s expected %b actual %b", $time, name, exp, act);
      mismatch_cnt++;
    end
  endtask

  task automatic report_failure(input string msg);
    $display("at %0t: %s", $time, msg);
    timing_cnt++;
  endtask

  // All outputs against the settled levels
  task automatic check_expected();
    for (int k = 0; k < N_STAGES; k++) begin
      check_ip_rst($sformatf("o_rst_ip_n[%0d]", k), expected_ip(k), o_rst_ip_n[k]);
      check_bit($sformatf("o_rst_ack_n[%0d]", k), ~&i_ack_ip[k], o_rst_ack_n[k]);
    end
    check_bit("o_rst_done_n", stage_level(N_STAGES-1) & ~&i_ack_ip[N_STAGES-1], o_rst_done_n);
  endtask

  // Call right after the releasing edge; records when each stage lets go
  task automatic measure_release(input int first);
    int  limit;
    int  hi;
    int  n;
    int  prev;
    logic busy;
    hi = 0;
    for (int k = first; k < N_STAGES; k++) hi += max_delay(k);
    limit = hi + 4;
    for (int k = 0; k < N_STAGES; k++) rel_cyc[k] = -1;
    n = 0;
    busy = 1'b1;
    while (busy) begin
      @(negedge i_clk);
      if (n == 0) start_cyc = cyc;
      for (int k = 0; k < N_STAGES; k++) begin
        if (rel_cyc[k] < 0 && o_rst_ip_n[k] == '1) rel_cyc[k] = cyc;
      end
      n++;
      busy = (o_rst_done_n !== 1'b1) && (n < limit);
    end
    prev = start_cyc;
    for (int k = first; k < N_STAGES; k++) begin
      if (rel_cyc[k] < 0) begin
        report_failure($sformatf("stage %0d IP resets never released", k));
      end else if (rel_cyc[k] < prev + min_delay(k)) begin
        report_failure($sformatf("stage %0d released at cycle %0d, before bound %0d",
                                 k, rel_cyc[k], prev + min_delay(k)));
      end
      if (rel_cyc[k] >= 0) prev = rel_cyc[k];
    end
    if (o_rst_done_n !== 1'b1) begin
      report_failure($sformatf("o_rst_done_n still asserted after %0d cycles", limit));
    end else if (cyc > start_cyc + hi) begin
      report_failure($sformatf("o_rst_done_n released at cycle %0d, past bound %0d",
                               cyc, start_cyc + hi));
    end
  endtask

  task automatic test_power_on_order();
    @(negedge i_clk);
    check_expected();  // All held while the top reset is low
    @(posedge i_clk);
    rst_sync_n <= 1'b1;
    measure_release(0);
    if (rel_cyc[0] != start_cyc) report_failure("stage 0 IP resets lagged rst_sync_n");
    check_expected();
  endtask

  task automatic test_stretch_zero_bypass();
    @(posedge i_clk);
    i_stretch_cycles <= '0;
    @(posedge i_clk);
    i_rst_req_n[1] <= 1'b0;
    @(negedge i_clk);
    check_expected();
    @(posedge i_clk);
    i_rst_req_n[1] <= 1'b1;
    @(negedge i_clk);
    check_expected();  // Same-cycle release through the bypass
    repeat (`RST_SYNC_DEPTH + 3) @(posedge i_clk);  // Let the stretch counters finish
    i_stretch_cycles <= stretch_rand;
    @(negedge i_clk);
    check_expected();
  endtask

  task automatic test_ip_sw_and_force();
    @(posedge i_clk);
    i_rst_ip_sw_n[0][1]  <= 1'b0;
    i_rst_ip_force[0][2] <= 1'b1;
    @(negedge i_clk);
    check_ip_rst("o_rst_ip_n[0]", 4'b1001, o_rst_ip_n[0]);  // Only IPs 1 and 2 held
    check_expected();
    @(posedge i_clk);
    i_rst_ip_sw_n[0][1]  <= 1'b1;
    i_rst_ip_force[0][2] <= 1'b0;
    @(negedge i_clk);
    check_expected();
  endtask

  task automatic test_source_mask();
    @(posedge i_clk);
    i_mask_rst_src[1][0] <= 1'b1;
    @(posedge i_clk);
    i_rst_src_n[1][0] <= 1'b0;  // Masked, nothing moves
    @(negedge i_clk);
    check_expected();
    @(posedge i_clk);
    i_rst_src_n[1][0] <= 1'b1;
    @(posedge i_clk);
    i_mask_rst_src[1][0] <= 1'b0;
    @(posedge i_clk);
    i_rst_src_n[1][0] <= 1'b0;
    @(negedge i_clk);
    check_expected();  // Stages 1 and 2 down, stage 0 up
    @(posedge i_clk);
    i_rst_src_n[1][0] <= 1'b1;
    measure_release(1);
    check_expected();
  endtask

  task automatic test_ack_backpressure();
    @(posedge i_clk);
    i_ack_ip[1] <= '1;
    @(negedge i_clk);
    check_expected();  // ack bit 1 low, stage 2 and done held
    @(posedge i_clk);
    i_ack_ip[1][0] <= 1'b0;
    measure_release(2);
    check_expected();
    @(posedge i_clk);
    i_ack_ip[1] <= '0;
    @(negedge i_clk);
    check_expected();
  endtask

  task automatic test_test_mode();
    @(posedge i_clk);
    i_stretch_cycles <= '0;  // Stretcher stages then follow the test reset directly
    @(posedge i_clk);
    i_test_mode <= 1'b1;
    @(posedge i_clk);
    i_rst_src_n[1][0] <= 1'b0;  // Ignored while in test mode
    @(negedge i_clk);
    check_expected();
    for (int i = 0; i < 4; i++) begin
      @(posedge i_clk);
      i_test_rst_n <= i[0];
      @(negedge i_clk);
      check_expected();
    end
    @(posedge i_clk);
    i_rst_src_n[1][0] <= 1'b1;
    @(posedge i_clk);
    i_test_mode <= 1'b0;
    @(negedge i_clk);
    check_expected();
  endtask

  initial begin
    rst_sync_n       <= 1'b0;
    i_test_mode      <= 1'b0;
    i_test_rst_n     <= 1'b1;
    i_rst_req_n      <= '1;
    i_rst_src_n      <= '1;
    i_mask_rst_src   <= '0;
    i_rst_ip_force   <= '0;
    i_rst_ip_sw_n    <= '1;
    i_ack_ip         <= '0;
    seed = 11345;
    for (int k = 0; k < N_STAGES; k++) begin
      stretch_rand[k] = stretch_t'($unsigned($random(seed)) % 21);  // 0..20
    end
    i_stretch_cycles <= stretch_rand;
    repeat (10) @(posedge i_clk);
    test_power_on_order();
    test_stretch_zero_bypass();
    test_ip_sw_and_force();
    test_source_mask();
    test_ack_backpressure();
    test_test_mode();
    $display("errors: %0d mismatches, %0d release failures", mismatch_cnt, timing_cnt);
    if (mismatch_cnt + timing_cnt == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  // Watchdog
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge i_clk);
    $display("timeout: tests still running after %0d cycles", WATCHDOG_CYCLES);
    $display("errors: %0d mismatches, %0d release failures", mismatch_cnt, timing_cnt);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

// ==== list.f ====
+incdir+design
design/rst_cfg_pkg.sv
design/rst_ip_pkg.sv
design/rst_n_sync.sv
design/rst_stage_block.sv
design/rst_seq_top.sv
bench/tb_rst_seq.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the reset sequencer testbench with Verilator
# Exit status is 0 only when the log holds the pass line

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir
BIN=tb_rst_seq

if ! command -v verilator >/dev/null 2>&1; then
  echo "verilator not found in PATH"
  exit 1
fi

rm -rf "$OBJ" "$LOG"

verilator --binary --timing --assert \
  --top-module tb_rst_seq \
  -f list.f \
  --Mdir "$OBJ" -o "$BIN"
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

"./$OBJ/$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^STATUS: PASS$" "$LOG"; then
  exit 0
fi
echo "pass line not found in $LOG"
exit 1
